// File: Bender.yml
package:
  name: bk_backend

sources:
  - files:
      - design/bk_pkg.sv
      - design/bk_regfile.sv
      - design/bk_alu.sv
      - design/bk_muler.sv
      - design/bk_cdb_arb.sv
      - design/bk_rob_ctrl.sv
      - design/bk_backend.sv
  - target: simulation
    files:
      - sim/bk_backend_tb.sv

// File: design/bk_alu.sv
`timescale 1ns/1ns
`default_nettype none

module bk_alu import bk_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      valid_i,
  output logic      ready_o,
  input  bk_issue_t req_i,
  output bk_cdb_t   cdb_o,
  input  logic      grant_i
);

  bk_cdb_t         out_q;
  logic [XLEN-1:0] result;

  always_comb begin
    case (req_i.op)
      OP_ADD:  result = req_i.a + req_i.b;
      OP_SUB:  result = req_i.a - req_i.b;
      OP_AND:  result = req_i.a & req_i.b;
      OP_OR:   result = req_i.a | req_i.b;
      OP_XOR:  result = req_i.a ^ req_i.b;
      OP_SLL:  result = req_i.a << req_i.b[4:0];
      // b already carries the sign-extended immediate
      OP_ADDI: result = req_i.a + req_i.b;
      default: result = '0;
    endcase
  end

  // free slot, or the held result leaves this cycle
  assign ready_o = !out_q.valid || grant_i;
  assign cdb_o   = out_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_q.valid <= 1'b0;
    end else if (valid_i && ready_o) begin
      out_q.valid <= 1'b1;
      out_q.tag   <= req_i.tag;
      out_q.data  <= result;
    end else if (grant_i) begin
      out_q.valid <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: design/bk_backend.sv
`timescale 1ns/1ns
`default_nettype none

module bk_backend import bk_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       pkg_valid_i,
  output logic       pkg_ready_o,
  input  bk_inst_t   pkg_i,
  output logic       retire_valid_o,
  output bk_retire_t retire_o
);

  logic [1:0][AREG_W-1:0] rf_raddr;
  logic [1:0][XLEN-1:0]   rf_rdata;
  logic                   rf_we;
  bk_retire_t             rf_wr;
  logic                   alu_valid;
  logic                   alu_ready;
  bk_issue_t              alu_req;
  logic                   mul_valid;
  logic                   mul_ready;
  bk_issue_t              mul_req;
  bk_cdb_t                alu_cdb;
  bk_cdb_t                mul_cdb;
  logic                   alu_grant;
  logic                   mul_grant;
  bk_cdb_t                cdb;

  bk_rob_ctrl u_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .pkg_valid_i    (pkg_valid_i),
    .pkg_ready_o    (pkg_ready_o),
    .pkg_i          (pkg_i),
    .rf_raddr_o     (rf_raddr),
    .rf_rdata_i     (rf_rdata),
    .rf_we_o        (rf_we),
    .rf_wr_o        (rf_wr),
    .alu_valid_o    (alu_valid),
    .alu_ready_i    (alu_ready),
    .alu_req_o      (alu_req),
    .mul_valid_o    (mul_valid),
    .mul_ready_i    (mul_ready),
    .mul_req_o      (mul_req),
    .cdb_i          (cdb),
    .retire_valid_o (retire_valid_o),
    .retire_o       (retire_o)
  );

  bk_regfile u_arf (
    .clk     (clk),
    .rst_n   (rst_n),
    .raddr_i (rf_raddr),
    .rdata_o (rf_rdata),
    .we_i    (rf_we),
    .wr_i    (rf_wr)
  );

  bk_alu u_alu (
    .clk     (clk),
    .rst_n   (rst_n),
    .valid_i (alu_valid),
    .ready_o (alu_ready),
    .req_i   (alu_req),
    .cdb_o   (alu_cdb),
    .grant_i (alu_grant)
  );

  bk_muler u_mul (
    .clk     (clk),
    .rst_n   (rst_n),
    .valid_i (mul_valid),
    .ready_o (mul_ready),
    .req_i   (mul_req),
    .cdb_o   (mul_cdb),
    .grant_i (mul_grant)
  );

  bk_cdb_arb u_arb (
    .alu_cdb_i   (alu_cdb),
    .mul_cdb_i   (mul_cdb),
    .alu_grant_o (alu_grant),
    .mul_grant_o (mul_grant),
    .cdb_o       (cdb)
  );

endmodule

`default_nettype wire

// File: design/bk_cdb_arb.sv
`timescale 1ns/1ns
`default_nettype none

module bk_cdb_arb import bk_pkg::*; (
  input  bk_cdb_t alu_cdb_i,
  input  bk_cdb_t mul_cdb_i,
  output logic    alu_grant_o,
  output logic    mul_grant_o,
  output bk_cdb_t cdb_o
);

  // fixed priority, multiplier first since its whole pipe stalls
  assign mul_grant_o = mul_cdb_i.valid;
  assign alu_grant_o = alu_cdb_i.valid && !mul_cdb_i.valid;

  always_comb begin
    if (mul_cdb_i.valid) begin
      cdb_o = mul_cdb_i;
    end else begin
      cdb_o = alu_cdb_i;
    end
  end

endmodule

`default_nettype wire

// File: design/bk_muler.sv
`timescale 1ns/1ns
`default_nettype none

module bk_muler import bk_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      valid_i,
  output logic      ready_o,
  input  bk_issue_t req_i,
  output bk_cdb_t   cdb_o,
  input  logic      grant_i
);

  bk_cdb_t [MUL_STAGES-1:0] pipe_q;
  // low halves of the two cross products
  logic [15:0] mid_lh_q;
  logic [15:0] mid_hl_q;
  logic [15:0] mid_q;
  logic        advance;

  // whole pipe stalls while the last stage waits for the bus
  assign advance = !pipe_q[MUL_STAGES-1].valid || grant_i;
  assign ready_o = advance;
  assign cdb_o   = pipe_q[MUL_STAGES-1];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < MUL_STAGES; i++) begin
        pipe_q[i].valid <= 1'b0;
      end
    end else if (advance) begin
      pipe_q[0].valid <= valid_i;
      pipe_q[0].tag   <= req_i.tag;
      for (int i = 1; i < MUL_STAGES; i++) begin
        pipe_q[i].valid <= pipe_q[i-1].valid;
        pipe_q[i].tag   <= pipe_q[i-1].tag;
      end
      // stage 1: 16x16 partial products
      pipe_q[0].data <= req_i.a[15:0] * req_i.b[15:0];
      mid_lh_q       <= req_i.a[15:0] * req_i.b[31:16];
      mid_hl_q       <= req_i.a[31:16] * req_i.b[15:0];
      // stage 2: fold the cross terms
      pipe_q[1].data <= pipe_q[0].data;
      mid_q          <= mid_lh_q + mid_hl_q;
      // stage 3: low word of the product
      pipe_q[MUL_STAGES-1].data <= pipe_q[1].data + {mid_q, 16'h0000};
    end
  end

endmodule

`default_nettype wire

// File: design/bk_pkg.sv
`default_nettype none

package bk_pkg;

  localparam int XLEN       = 32;
  localparam int AREG_W     = 4;
  localparam int ROB_DEPTH  = 8;
  localparam int ROB_W      = 3;
  localparam int MUL_STAGES = 3;

  typedef enum logic [2:0] {
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_SLL,
    OP_ADDI,
    OP_MUL
  } bk_op_e;

  // register form of the operand field
  typedef struct packed {
    logic [AREG_W-1:0] rs2;
    logic [15-AREG_W:0] pad;
  } bk_operand_reg_t;

  // second source register, or the ADDI immediate
  typedef union packed {
    bk_operand_reg_t    r;
    logic signed [15:0] imm;
  } bk_operand_u;

  // decoded packet from the front end
  typedef struct packed {
    bk_op_e            op;
    logic [AREG_W-1:0] rd;
    logic [AREG_W-1:0] rs1;
    bk_operand_u       operand;
  } bk_inst_t;

  typedef struct packed {
    bk_op_e           op;
    logic [ROB_W-1:0] tag;
    logic [XLEN-1:0]  a;
    logic [XLEN-1:0]  b;
  } bk_issue_t;

  typedef struct packed {
    logic             valid;
    logic [ROB_W-1:0] tag;
    logic [XLEN-1:0]  data;
  } bk_cdb_t;

  typedef struct packed {
    logic [AREG_W-1:0] rd;
    logic [XLEN-1:0]   data;
  } bk_retire_t;

endpackage

`default_nettype wire

// File: design/bk_regfile.sv
`timescale 1ns/1ns
`default_nettype none

module bk_regfile import bk_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [1:0][AREG_W-1:0] raddr_i,
  output logic [1:0][XLEN-1:0]   rdata_o,
  input  logic                   we_i,
  input  bk_retire_t             wr_i
);

  logic [XLEN-1:0] regs_q [1<<AREG_W];
  logic            wr_en;

  // r0 is never written, so it stays zero after reset
  assign wr_en = we_i && (wr_i.rd != '0);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < (1 << AREG_W); i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_en) begin
      regs_q[wr_i.rd] <= wr_i.data;
    end
  end

  // write-through on same-cycle collision
  always_comb begin
    for (int p = 0; p < 2; p++) begin
      rdata_o[p] = (wr_en && wr_i.rd == raddr_i[p]) ? wr_i.data : regs_q[raddr_i[p]];
    end
  end

endmodule

`default_nettype wire

// File: design/bk_rob_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module bk_rob_ctrl import bk_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   pkg_valid_i,
  output logic                   pkg_ready_o,
  input  bk_inst_t               pkg_i,
  output logic [1:0][AREG_W-1:0] rf_raddr_o,
  input  logic [1:0][XLEN-1:0]   rf_rdata_i,
  output logic                   rf_we_o,
  output bk_retire_t             rf_wr_o,
  output logic                   alu_valid_o,
  input  logic                   alu_ready_i,
  output bk_issue_t              alu_req_o,
  output logic                   mul_valid_o,
  input  logic                   mul_ready_i,
  output bk_issue_t              mul_req_o,
  input  bk_cdb_t                cdb_i,
  output logic                   retire_valid_o,
  output bk_retire_t             retire_o
);

  // rename table
  logic [(1<<AREG_W)-1:0]            rat_busy_q;
  logic [(1<<AREG_W)-1:0][ROB_W-1:0] rat_tag_q;
  // reorder buffer
  logic [AREG_W-1:0]    rob_rd_q   [ROB_DEPTH];
  logic [XLEN-1:0]      rob_data_q [ROB_DEPTH];
  logic [ROB_DEPTH-1:0] rob_done_q;
  logic [ROB_W-1:0]     head_q;
  logic [ROB_W-1:0]     tail_q;
  logic [ROB_W:0]       count_q;
  logic                 live_q;

  logic [1:0][ROB_W-1:0] src_tag;
  logic [1:0]            src_ok;
  logic [1:0][XLEN-1:0]  src_val;
  logic                  is_mul;
  logic                  is_addi;
  logic                  unit_ready;
  logic                  fire;
  logic                  commit;
  logic [AREG_W-1:0]     head_rd;
  bk_issue_t             issue;

  assign rf_raddr_o[0] = pkg_i.rs1;
  assign rf_raddr_o[1] = pkg_i.operand.r.rs2;

  // operand source: register file, then done ROB entry, then bus
  always_comb begin
    for (int s = 0; s < 2; s++) begin
      src_tag[s] = rat_tag_q[rf_raddr_o[s]];
      src_ok[s]  = 1'b0;
      src_val[s] = rf_rdata_i[s];
      if (rf_raddr_o[s] == '0 || !rat_busy_q[rf_raddr_o[s]]) begin
        src_ok[s] = 1'b1;
      end else if (rob_done_q[src_tag[s]]) begin
        src_ok[s]  = 1'b1;
        src_val[s] = rob_data_q[src_tag[s]];
      end else if (cdb_i.valid && cdb_i.tag == src_tag[s]) begin
        src_ok[s]  = 1'b1;
        src_val[s] = cdb_i.data;
      end
    end
  end

  assign is_mul     = (pkg_i.op == OP_MUL);
  assign is_addi    = (pkg_i.op == OP_ADDI);
  assign unit_ready = is_mul ? mul_ready_i : alu_ready_i;

  assign pkg_ready_o = live_q && (count_q != ROB_DEPTH) && src_ok[0]
                       && (is_addi || src_ok[1]) && unit_ready;
  assign fire        = pkg_valid_i && pkg_ready_o;

  always_comb begin
    issue.op  = pkg_i.op;
    issue.tag = tail_q;
    issue.a   = src_val[0];
    issue.b   = is_addi ? {{(XLEN-16){pkg_i.operand.imm[15]}}, pkg_i.operand.imm} : src_val[1];
  end

  assign alu_req_o   = issue;
  assign mul_req_o   = issue;
  assign alu_valid_o = fire && !is_mul;
  assign mul_valid_o = fire && is_mul;

  assign commit  = (count_q != '0) && rob_done_q[head_q];
  assign head_rd = rob_rd_q[head_q];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      live_q         <= 1'b0;
      rat_busy_q     <= '0;
      rob_done_q     <= '0;
      head_q         <= '0;
      tail_q         <= '0;
      count_q        <= '0;
      retire_valid_o <= 1'b0;
    end else begin
      live_q         <= 1'b1;
      retire_valid_o <= commit;
      if (commit) begin
        head_q <= head_q + 1'b1;
        // a younger writer may already own the mapping
        if (head_rd != '0 && rat_tag_q[head_rd] == head_q) begin
          rat_busy_q[head_rd] <= 1'b0;
        end
      end
      if (fire) begin
        tail_q             <= tail_q + 1'b1;
        rob_done_q[tail_q] <= 1'b0;
        if (pkg_i.rd != '0) begin
          rat_busy_q[pkg_i.rd] <= 1'b1;
          rat_tag_q[pkg_i.rd]  <= tail_q;
        end
      end
      if (cdb_i.valid) begin
        rob_done_q[cdb_i.tag] <= 1'b1;
      end
      case ({fire, commit})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (fire) begin
      rob_rd_q[tail_q] <= pkg_i.rd;
    end
    if (cdb_i.valid) begin
      rob_data_q[cdb_i.tag] <= cdb_i.data;
    end
    retire_o.rd   <= head_rd;
    retire_o.data <= rob_data_q[head_q];
  end

  // register file written one cycle after the pop
  assign rf_we_o = retire_valid_o;
  assign rf_wr_o = retire_o;

endmodule

`default_nettype wire

// File: files.f
design/bk_pkg.sv
design/bk_regfile.sv
design/bk_alu.sv
design/bk_muler.sv
design/bk_cdb_arb.sv
design/bk_rob_ctrl.sv
design/bk_backend.sv
sim/bk_backend_tb.sv

// File: sim/bk_backend_tb.sv
`timescale 1ns/1ns
`default_nettype none

module bk_backend_tb import bk_pkg::*;;

  localparam int N_INST     = 400;
  localparam int RST_CYCLES = 4;
  localparam int WDOG_CYC   = RST_CYCLES + N_INST * 20;

  logic       clk = 1'b0;
  logic       rst_n;
  logic       pkg_valid_i;
  logic       pkg_ready_o;
  bk_inst_t   pkg_i;
  logic       retire_valid_o;
  bk_retire_t retire_o;

  integer          seed = 32'hc9eed5f1;
  logic [XLEN-1:0] shadow [1<<AREG_W];
  bk_retire_t      exp_q [$];
  int              retired = 0;

  bk_backend UUT (
    .clk            (clk),
    .rst_n          (rst_n),
    .pkg_valid_i    (pkg_valid_i),
    .pkg_ready_o    (pkg_ready_o),
    .pkg_i          (pkg_i),
    .retire_valid_o (retire_valid_o),
    .retire_o       (retire_o)
  );

  always #4 clk = ~clk;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("test failed");
    $fatal(1);
  endtask

  task automatic check_retire(input bk_retire_t got, input bk_retire_t exp);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] retire_o got rd %h data %h, expected rd %h data %h",
                          got.rd, got.data, exp.rd, exp.data));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] %s got %h, expected %h", name, got, exp));
    end
  endtask

  // in-order reference executed at acceptance, r0 always reads zero
  function automatic bk_retire_t model_exec(input bk_inst_t inst);
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    int              imm_ext;
    bk_retire_t      res;
    a       = shadow[inst.rs1];
    b       = shadow[inst.operand.r.rs2];
    imm_ext = inst.operand.imm;
    case (inst.op)
      OP_ADD:  res.data = a + b;
      OP_SUB:  res.data = a - b;
      OP_AND:  res.data = a & b;
      OP_OR:   res.data = a | b;
      OP_XOR:  res.data = a ^ b;
      OP_SLL:  res.data = a << b[4:0];
      OP_ADDI: res.data = a + imm_ext;
      default: res.data = a * b;
    endcase
    res.rd = inst.rd;
    if (inst.rd != 0) begin
      shadow[inst.rd] = res.data;
    end
    return res;
  endfunction

  // few registers and extra MUL weight so hazards are frequent
  task automatic make_inst(input logic [AREG_W-1:0] prev_rd, output bk_inst_t inst);
    logic [31:0] rnd;
    int          sel;
    sel = $unsigned($random(seed)) % 16;
    if (sel < 5) begin
      inst.op = OP_MUL;
    end else begin
      inst.op = bk_op_e'(sel % 7);
    end
    inst.rd  = AREG_W'($unsigned($random(seed)) % 5);
    inst.rs1 = AREG_W'($unsigned($random(seed)) % 5);
    rnd = $random(seed);
    inst.operand.imm = rnd[15:0];
    if (inst.op != OP_ADDI) begin
      inst.operand.r.rs2 = AREG_W'($unsigned($random(seed)) % 5);
      if (rnd[17:16] == 2'b00) begin
        inst.operand.r.rs2 = prev_rd;
      end
    end
    // read-after-write chain on the previous destination
    if (rnd[18]) begin
      inst.rs1 = prev_rd;
    end
  endtask

  always @(negedge clk) begin
    if (rst_n === 1'b1 && retire_valid_o) begin
      if (exp_q.size() == 0) begin
        abort_run("retirement seen with no accepted instruction outstanding");
      end else begin
        check_retire(retire_o, exp_q.pop_front());
        retired++;
      end
    end
  end

  initial begin : watchdog
    repeat (WDOG_CYC) @(posedge clk);
    abort_run("timeout, the backend did not retire all instructions in time");
  end

  initial begin : main_seq
    bk_inst_t          inst;
    logic [AREG_W-1:0] prev_rd;
    rst_n       = 1'b0;
    pkg_valid_i = 1'b0;
    pkg_i       = '0;
    prev_rd     = '0;
    for (int r = 0; r < (1 << AREG_W); r++) begin
      shadow[r] = '0;
    end
    for (int c = 0; c < RST_CYCLES; c++) begin
      @(posedge clk);
      #1;
      check_flag("pkg_ready_o", pkg_ready_o, 1'b0);
      check_flag("retire_valid_o", retire_valid_o, 1'b0);
    end
    rst_n = 1'b1;
    for (int n = 0; n < N_INST; n++) begin
      make_inst(prev_rd, inst);
      // occasional front-end bubble
      if (($random(seed) & 7) == 0) begin
        pkg_valid_i = 1'b0;
        @(posedge clk);
        #1;
      end
      pkg_valid_i = 1'b1;
      pkg_i       = inst;
      @(negedge clk);
      while (!pkg_ready_o) begin
        @(negedge clk);
      end
      @(posedge clk);
      #1;
      exp_q.push_back(model_exec(inst));
      prev_rd = inst.rd;
    end
    pkg_valid_i = 1'b0;
    while (retired < N_INST) begin
      @(posedge clk);
    end
    // drain a little longer to catch stray retirements
    repeat (8) @(posedge clk);
    #2;
    if (retire_valid_o === 1'b0) begin
      $display("test passed");
      $finish;
    end else begin
      abort_run($sformatf("[FAIL] retire_valid_o got %h after the drain, expected %h",
                          retire_valid_o, 1'b0));
    end
  end

endmodule

`default_nettype wire
